/* Makefile */
TOP = tb_mips_mem_wb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): mips_mem_wb_top.f src/*.sv testbench/*.sv
	verilator --binary --timing -j 0 -f mips_mem_wb_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^all tests passed$$" $(LOG)

lint:
	verilator --lint-only --timing -f mips_mem_wb_top.f --top-module mips_mem_wb_top

clean:
	rm -rf obj_dir $(LOG)

/* mips_mem_wb_top.f */
src/mips_arch_pkg.sv
src/mips_ctrl_pkg.sv
src/data_memory.sv
src/mem_wb_reg.sv
src/writeback_select.sv
src/register_file.sv
src/mips_mem_wb_top.sv
testbench/tb_mips_mem_wb.sv

/* src/data_memory.sv */
`timescale 1ns/1ps

module data_memory
    import mips_ctrl_pkg::*;
#(
    parameter int NBITS     = 32,
    parameter int MEM_WORDS = 256
)
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic [NBITS-1:0]   i_addr,
    input  logic [NBITS-1:0]   i_wdata,
    input  logic               i_write,
    input  access_size_t       i_size,
    output logic [NBITS-1:0]   o_rdata
);

    localparam int LANES     = NBITS / 8;
    localparam int LANE_BITS = $clog2(LANES);
    localparam int AW        = $clog2(MEM_WORDS);

    logic [NBITS-1:0]     mem [MEM_WORDS];
    logic [AW-1:0]        word_idx;
    logic [LANE_BITS-1:0] byte_off;
    logic [LANES-1:0]     lane_en;
    logic [NBITS-1:0]     lane_data;

    assign byte_off = i_addr[LANE_BITS-1:0];
    assign word_idx = i_addr[LANE_BITS +: AW];

    // Lane enables and store data replicated across lanes
    always_comb
    begin
        lane_en   = '0;
        lane_data = i_wdata;
        case (i_size)
            SIZE_BYTE:
            begin
                lane_en[byte_off] = 1'b1;
                lane_data         = {LANES{i_wdata[7:0]}};
            end
            SIZE_HALF:
            begin
                // Lane pair picked by the upper offset bits
                lane_en   = LANES'(2'b11) << {byte_off[LANE_BITS-1:1], 1'b0};
                lane_data = {(LANES/2){i_wdata[15:0]}};
            end
            default:
            begin
                lane_en = '1;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int w = 0; w < MEM_WORDS; w++)
            begin
                mem[w] <= '0;
            end
        end
        else if (i_write)
        begin
            for (int b = 0; b < LANES; b++)
            begin
                if (lane_en[b])
                begin
                    mem[word_idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    // Whole aligned word for write-back to pick the lanes from
    assign o_rdata = mem[word_idx];

endmodule

/* src/mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg
    import mips_ctrl_pkg::*;
#(
    parameter int NBITS  = 32,
    parameter int RNBITS = 5
)
(
    input  logic               i_clk,
    input  logic               i_rst_n,

    // Data from the memory stage
    input  logic [NBITS-1:0]   i_alu,
    input  logic [NBITS-1:0]   i_mem_data,
    input  logic [NBITS-1:0]   i_link_pc,
    input  logic [NBITS-1:0]   i_extension,
    input  logic [RNBITS-1:0]  i_rd,

    // Write-back control
    input  access_size_t       i_load_size,
    input  logic               i_zero_extend,
    input  wb_src_t            i_wb_src,
    input  logic               i_reg_write,

    output logic [NBITS-1:0]   o_alu,
    output logic [NBITS-1:0]   o_mem_data,
    output logic [NBITS-1:0]   o_link_pc,
    output logic [NBITS-1:0]   o_extension,
    output logic [RNBITS-1:0]  o_rd,

    output access_size_t       o_load_size,
    output logic               o_zero_extend,
    output wb_src_t            o_wb_src,
    output logic               o_reg_write
);

    // ************************************************************
    // Payload and decode fields, advanced every clock
    // ************************************************************

    always_ff @(posedge i_clk)
    begin
        o_alu         <= i_alu;
        o_mem_data    <= i_mem_data;
        o_link_pc     <= i_link_pc;
        o_extension   <= i_extension;
        o_rd          <= i_rd;
        o_load_size   <= i_load_size;
        o_zero_extend <= i_zero_extend;
        o_wb_src      <= i_wb_src;
    end

    // ************************************************************
    // Register write enable
    // ************************************************************

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_reg_write <= 1'b0;
        end
        else
        begin
            o_reg_write <= i_reg_write;
        end
    end

endmodule

/* src/mips_arch_pkg.sv */
package mips_arch_pkg;

    // ************************************************************
    // Architectural widths of the integer datapath
    // ************************************************************

    // Data and address width
    localparam int NBITS = 32;

    // Register number width for 32 general purpose registers
    localparam int RNBITS = 5;

    // Data memory depth in words
    localparam int MEM_WORDS = 256;

endpackage

/* src/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

    // ************************************************************
    // Memory access and write-back control encodings
    // ************************************************************

    // Access size shared by stores and loads
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    // Source of the value written back to the register file
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LUI  = 2'd2,
        WB_LINK = 2'd3
    } wb_src_t;

endpackage

/* src/mips_mem_wb_top.sv */
`timescale 1ns/1ps

module mips_mem_wb_top
    import mips_ctrl_pkg::*;
#(
    parameter int NBITS     = mips_arch_pkg::NBITS,
    parameter int RNBITS    = mips_arch_pkg::RNBITS,
    parameter int MEM_WORDS = mips_arch_pkg::MEM_WORDS
)
(
    input  logic               i_clk,
    input  logic               i_rst_n,

    // From the execute stage
    input  logic [NBITS-1:0]   i_alu,
    input  logic [NBITS-1:0]   i_store_data,
    input  logic [NBITS-1:0]   i_link_pc,
    input  logic [NBITS-1:0]   i_extension,
    input  logic [RNBITS-1:0]  i_rd,
    input  logic               i_mem_write,
    input  access_size_t       i_mem_size,
    input  logic               i_zero_extend,
    input  wb_src_t            i_wb_src,
    input  logic               i_reg_write,

    // Register read ports
    input  logic [RNBITS-1:0]  i_rs_addr,
    input  logic [RNBITS-1:0]  i_rt_addr,
    output logic [NBITS-1:0]   o_rs_data,
    output logic [NBITS-1:0]   o_rt_data,

    // Write-back port as seen by the register file
    output logic               o_wb_write,
    output logic [RNBITS-1:0]  o_wb_addr,
    output logic [NBITS-1:0]   o_wb_data
);

    logic [NBITS-1:0] mem_rdata;
    logic [NBITS-1:0] wb_alu;
    logic [NBITS-1:0] wb_mem_data;
    logic [NBITS-1:0] wb_link_pc;
    logic [NBITS-1:0] wb_extension;
    access_size_t     wb_load_size;
    logic             wb_zero_extend;
    wb_src_t          wb_src;

    // ************************************************************
    // Memory stage
    // ************************************************************

    data_memory #(
        .NBITS     (NBITS),
        .MEM_WORDS (MEM_WORDS)
    ) u_data_memory (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_addr  (i_alu),
        .i_wdata (i_store_data),
        .i_write (i_mem_write),
        .i_size  (i_mem_size),
        .o_rdata (mem_rdata)
    );

    mem_wb_reg #(
        .NBITS  (NBITS),
        .RNBITS (RNBITS)
    ) u_mem_wb_reg (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_alu         (i_alu),
        .i_mem_data    (mem_rdata),
        .i_link_pc     (i_link_pc),
        .i_extension   (i_extension),
        .i_rd          (i_rd),
        .i_load_size   (i_mem_size),
        .i_zero_extend (i_zero_extend),
        .i_wb_src      (i_wb_src),
        .i_reg_write   (i_reg_write),
        .o_alu         (wb_alu),
        .o_mem_data    (wb_mem_data),
        .o_link_pc     (wb_link_pc),
        .o_extension   (wb_extension),
        .o_rd          (o_wb_addr),
        .o_load_size   (wb_load_size),
        .o_zero_extend (wb_zero_extend),
        .o_wb_src      (wb_src),
        .o_reg_write   (o_wb_write)
    );

    // ************************************************************
    // Write-back stage
    // ************************************************************

    writeback_select #(
        .NBITS (NBITS)
    ) u_writeback_select (
        .i_alu         (wb_alu),
        .i_mem_data    (wb_mem_data),
        .i_link_pc     (wb_link_pc),
        .i_extension   (wb_extension),
        .i_load_size   (wb_load_size),
        .i_zero_extend (wb_zero_extend),
        .i_wb_src      (wb_src),
        .o_wb_data     (o_wb_data)
    );

    register_file #(
        .NBITS  (NBITS),
        .RNBITS (RNBITS)
    ) u_register_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_write   (o_wb_write),
        .i_waddr   (o_wb_addr),
        .i_wdata   (o_wb_data),
        .i_raddr_a (i_rs_addr),
        .i_raddr_b (i_rt_addr),
        .o_rdata_a (o_rs_data),
        .o_rdata_b (o_rt_data)
    );

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file
#(
    parameter int NBITS  = 32,
    parameter int RNBITS = 5
)
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_write,
    input  logic [RNBITS-1:0]  i_waddr,
    input  logic [NBITS-1:0]   i_wdata,
    input  logic [RNBITS-1:0]  i_raddr_a,
    input  logic [RNBITS-1:0]  i_raddr_b,
    output logic [NBITS-1:0]   o_rdata_a,
    output logic [NBITS-1:0]   o_rdata_b
);

    localparam int NREGS = 2 ** RNBITS;

    logic [NBITS-1:0] regs [NREGS];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int r = 0; r < NREGS; r++)
            begin
                regs[r] <= '0;
            end
        end
        else if (i_write && (i_waddr != '0))
        begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Read ports show a write only after its edge
    assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

/* src/writeback_select.sv */
`timescale 1ns/1ps

module writeback_select
    import mips_ctrl_pkg::*;
#(
    parameter int NBITS = 32
)
(
    input  logic [NBITS-1:0]   i_alu,
    input  logic [NBITS-1:0]   i_mem_data,
    input  logic [NBITS-1:0]   i_link_pc,
    input  logic [NBITS-1:0]   i_extension,
    input  access_size_t       i_load_size,
    input  logic               i_zero_extend,
    input  wb_src_t            i_wb_src,
    output logic [NBITS-1:0]   o_wb_data
);

    localparam int LANE_BITS = $clog2(NBITS / 8);

    logic [NBITS-1:0] byte_shift;
    logic [NBITS-1:0] half_shift;
    logic [7:0]       load_byte;
    logic [15:0]      load_half;
    logic [NBITS-1:0] load_data;

    // Move the addressed byte or half down to bit 0
    assign byte_shift = i_mem_data >> {i_alu[LANE_BITS-1:0], 3'b000};
    assign half_shift = i_mem_data >> {i_alu[LANE_BITS-1:1], 4'b0000};
    assign load_byte  = byte_shift[7:0];
    assign load_half  = half_shift[15:0];

    // Load filter
    always_comb
    begin
        case (i_load_size)
            SIZE_BYTE:
            begin
                if (i_zero_extend)
                    load_data = {{(NBITS-8){1'b0}}, load_byte};
                else
                    load_data = {{(NBITS-8){load_byte[7]}}, load_byte};
            end
            SIZE_HALF:
            begin
                if (i_zero_extend)
                    load_data = {{(NBITS-16){1'b0}}, load_half};
                else
                    load_data = {{(NBITS-16){load_half[15]}}, load_half};
            end
            default:
            begin
                load_data = i_mem_data;
            end
        endcase
    end

    // Result select
    always_comb
    begin
        case (i_wb_src)
            WB_MEM:  o_wb_data = load_data;
            WB_LUI:  o_wb_data = {i_extension[15:0], {(NBITS-16){1'b0}}};
            WB_LINK: o_wb_data = i_link_pc;
            default: o_wb_data = i_alu;
        endcase
    end

endmodule

/* testbench/tb_mips_mem_wb.sv */
`timescale 1ns/1ps

module tb_mips_mem_wb
    import mips_ctrl_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    localparam int CYCLE_BUDGET = 100;
    localparam int TIMEOUT_NS   = NUM_TESTS * CYCLE_BUDGET * CLK_PERIOD * 2;

    logic         i_clk;
    logic         i_rst_n;
    logic [31:0]  i_alu;
    logic [31:0]  i_store_data;
    logic [31:0]  i_link_pc;
    logic [31:0]  i_extension;
    logic [4:0]   i_rd;
    logic         i_mem_write;
    access_size_t i_mem_size;
    logic         i_zero_extend;
    wb_src_t      i_wb_src;
    logic         i_reg_write;
    logic [4:0]   i_rs_addr;
    logic [4:0]   i_rt_addr;
    logic [31:0]  o_rs_data;
    logic [31:0]  o_rt_data;
    logic         o_wb_write;
    logic [4:0]   o_wb_addr;
    logic [31:0]  o_wb_data;

    // Reference model with memory kept as bytes
    logic [7:0]   mem_model [1024];
    logic [31:0]  reg_model [32];

    // Operation sampled at the next edge, and the one in write-back
    logic         iss_write;
    logic [4:0]   iss_addr;
    logic [31:0]  iss_data;
    logic         wb_write_exp;
    logic [4:0]   wb_addr_exp;
    logic [31:0]  wb_data_exp;

    logic [4:0]   rs_sel;
    logic [4:0]   rt_sel;
    integer       seed;

    mips_mem_wb_top i_dut (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_alu (i_alu), .i_store_data (i_store_data),
        .i_link_pc (i_link_pc), .i_extension (i_extension), .i_rd (i_rd),
        .i_mem_write (i_mem_write), .i_mem_size (i_mem_size),
        .i_zero_extend (i_zero_extend), .i_wb_src (i_wb_src), .i_reg_write (i_reg_write),
        .i_rs_addr (i_rs_addr), .i_rt_addr (i_rt_addr),
        .o_rs_data (o_rs_data), .o_rt_data (o_rt_data),
        .o_wb_write (o_wb_write), .o_wb_addr (o_wb_addr), .o_wb_data (o_wb_data)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ************************************************************
    // Reference model
    // ************************************************************

    function automatic logic [31:0] loaded_value(input logic [31:0] addr,
                                                 input access_size_t size, input logic zext);
        logic [9:0]  a;
        logic [15:0] half;
        logic [31:0] value;
        a = addr[9:0];
        case (size)
            SIZE_BYTE:
                value = zext ? {24'h0, mem_model[a]} : {{24{mem_model[a][7]}}, mem_model[a]};
            SIZE_HALF:
            begin
                a[0] = 1'b0;
                half = {mem_model[a + 10'd1], mem_model[a]};
                value = zext ? {16'h0, half} : {{16{half[15]}}, half};
            end
            default:
            begin
                a[1:0] = 2'b00;
                value = {mem_model[a + 10'd3], mem_model[a + 10'd2],
                         mem_model[a + 10'd1], mem_model[a]};
            end
        endcase
        return value;
    endfunction

    function automatic logic [31:0] expected_result(input logic [31:0] alu,
        input logic [31:0] link, input logic [31:0] ext, input access_size_t size,
        input logic zext, input wb_src_t src);
        logic [31:0] value;
        case (src)
            WB_MEM:  value = loaded_value(alu, size, zext);
            WB_LUI:  value = {ext[15:0], 16'h0000};
            WB_LINK: value = link;
            default: value = alu;
        endcase
        return value;
    endfunction

    task automatic store_model(input logic [31:0] addr, input logic [31:0] data,
                               input access_size_t size);
        logic [9:0] a;
        a = addr[9:0];
        if (size == SIZE_BYTE)
            mem_model[a] = data[7:0];
        else if (size == SIZE_HALF)
        begin
            a[0] = 1'b0;
            mem_model[a] = data[7:0];
            mem_model[a + 10'd1] = data[15:8];
        end
        else
        begin
            a[1:0] = 2'b00;
            for (int b = 0; b < 4; b++)
                mem_model[a + 10'(b)] = data[8*b +: 8];
        end
    endtask

    function automatic logic [4:0] random_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERR time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // ************************************************************
    // One clock of stimulus with write-back and read port checks
    // ************************************************************

    task automatic step(input logic [31:0] alu, input logic [31:0] store_data,
        input logic [31:0] link, input logic [31:0] ext, input logic [4:0] rd,
        input logic mem_write, input access_size_t size, input logic zext,
        input wb_src_t src, input logic reg_write);
        @(posedge i_clk);
        // Older operation commits and the previous one enters write-back
        if (wb_write_exp && wb_addr_exp != 5'd0)
            reg_model[wb_addr_exp] = wb_data_exp;
        wb_write_exp = iss_write;
        wb_addr_exp  = iss_addr;
        wb_data_exp  = iss_data;
        iss_write = reg_write;
        iss_addr  = rd;
        iss_data  = expected_result(alu, link, ext, size, zext, src);
        if (mem_write)
            store_model(alu, store_data, size);
        i_alu <= alu;
        i_store_data <= store_data;
        i_link_pc <= link;
        i_extension <= ext;
        i_rd <= rd;
        i_mem_write <= mem_write;
        i_mem_size <= size;
        i_zero_extend <= zext;
        i_wb_src <= src;
        i_reg_write <= reg_write;
        i_rs_addr <= rs_sel;
        i_rt_addr <= rt_sel;
        @(negedge i_clk);
        check_value("o_wb_write", 32'(o_wb_write), 32'(wb_write_exp));
        if (wb_write_exp)
        begin
            check_value("o_wb_addr", 32'(o_wb_addr), 32'(wb_addr_exp));
            check_value("o_wb_data", o_wb_data, wb_data_exp);
        end
        check_value("o_rs_data", o_rs_data, reg_model[rs_sel]);
        check_value("o_rt_data", o_rt_data, reg_model[rt_sel]);
    endtask

    task automatic bubble();
        step(32'h0, 32'h0, 32'h0, 32'h0, 5'd0, 1'b0, SIZE_WORD, 1'b0, WB_ALU, 1'b0);
    endtask

    task automatic op_alu(input logic [4:0] rd, input logic [31:0] value, input logic we);
        step(value, 32'h0, 32'h0, 32'h0, rd, 1'b0, SIZE_WORD, 1'b0, WB_ALU, we);
    endtask

    task automatic op_store(input logic [31:0] addr, input logic [31:0] data,
                            input access_size_t size);
        step(addr, data, 32'h0, 32'h0, 5'd0, 1'b1, size, 1'b0, WB_ALU, 1'b0);
    endtask

    task automatic op_load(input logic [4:0] rd, input logic [31:0] addr,
                           input access_size_t size, input logic zext);
        step(addr, 32'h0, 32'h0, 32'h0, rd, 1'b0, size, zext, WB_MEM, 1'b1);
    endtask

    // ************************************************************
    // Directed tests
    // ************************************************************

    task automatic test_reset_idle();
        logic [31:0] r;
        for (int i = 0; i < 8; i++)
        begin
            r = $random(seed);
            rs_sel = r[4:0];
            rt_sel = r[9:5];
            bubble();
        end
    endtask

    task automatic test_word_path();
        logic [4:0] rd;
        logic [4:0] rd_prev;
        logic [4:0] rd_older;
        rd_prev  = 5'd1;
        rd_older = 5'd1;
        for (int i = 0; i < 16; i++)
        begin
            rd = random_reg();
            // Register written two clocks back is now visible
            rs_sel = rd_older;
            rt_sel = rd_prev;
            op_alu(rd, $random(seed), 1'b1);
            rd_older = rd_prev;
            rd_prev  = rd;
        end
        bubble();
        bubble();
    endtask

    task automatic test_sized_stores();
        logic [31:0] base;
        base = 32'h0000_0140;
        rs_sel = 5'd9;
        rt_sel = 5'd10;
        op_store(base + 32'd4, 32'h5A5A_5A5A, SIZE_WORD);
        op_store(base, $random(seed), SIZE_WORD);
        op_load(5'd9, base, SIZE_WORD, 1'b0);
        for (int off = 0; off < 4; off++)
        begin
            op_store(base + 32'(off), $random(seed), SIZE_BYTE);
            op_load(5'd9, base, SIZE_WORD, 1'b0);
        end
        for (int off = 0; off < 4; off += 2)
        begin
            op_store(base + 32'(off), $random(seed), SIZE_HALF);
            op_load(5'd10, base, SIZE_WORD, 1'b0);
        end
        op_load(5'd10, base + 32'd4, SIZE_WORD, 1'b0);
        bubble();
        bubble();
    endtask

    task automatic test_sized_loads();
        logic [31:0] base;
        base = 32'h0000_0200;
        rs_sel = 5'd12;
        rt_sel = 5'd13;
        // Top bit set in every byte and both halves
        op_store(base, 32'h8FF0_A5C3, SIZE_WORD);
        for (int z = 0; z < 2; z++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                op_load(5'd12, base + 32'(off), SIZE_BYTE, z[0]);
                if (off % 2 == 0)
                    op_load(5'd13, base + 32'(off), SIZE_HALF, z[0]);
            end
            op_load(5'd13, base, SIZE_WORD, z[0]);
        end
        bubble();
        bubble();
    endtask

    task automatic test_lui_link();
        rs_sel = 5'd20;
        rt_sel = 5'd21;
        for (int i = 0; i < 4; i++)
        begin
            step(32'h0, 32'h0, 32'h0, $random(seed), 5'd20, 1'b0, SIZE_WORD, 1'b0,
                 WB_LUI, 1'b1);
            step(32'h0, 32'h0, $random(seed), 32'h0, 5'd21, 1'b0, SIZE_WORD, 1'b0,
                 WB_LINK, 1'b1);
        end
        bubble();
        bubble();
    endtask

    task automatic test_no_write();
        rs_sel = 5'd7;
        rt_sel = 5'd0;
        op_alu(5'd7, 32'h1234_5678, 1'b1);
        op_alu(5'd7, 32'hDEAD_BEEF, 1'b0);
        bubble();
        bubble();
        check_value("o_rs_data", o_rs_data, 32'h1234_5678);
        rs_sel = 5'd0;
        op_alu(5'd0, 32'hFFFF_FFFF, 1'b1);
        bubble();
        bubble();
        check_value("o_rs_data", o_rs_data, 32'h0);
    endtask

    // ************************************************************
    // Main sequence and watchdog
    // ************************************************************

    initial
    begin
        seed = 32'h7417;
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_alu = '0;
        i_store_data = '0;
        i_link_pc = '0;
        i_extension = '0;
        i_rd = '0;
        i_mem_write = 1'b0;
        i_mem_size = SIZE_WORD;
        i_zero_extend = 1'b0;
        i_wb_src = WB_ALU;
        i_reg_write = 1'b0;
        i_rs_addr = '0;
        i_rt_addr = '0;
        for (int i = 0; i < 1024; i++)
            mem_model[i] = 8'h00;
        for (int i = 0; i < 32; i++)
            reg_model[i] = 32'h0;
        iss_write = 1'b0;
        iss_addr = '0;
        iss_data = '0;
        wb_write_exp = 1'b0;
        wb_addr_exp = '0;
        wb_data_exp = '0;
        rs_sel = '0;
        rt_sel = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;
        test_reset_idle();
        test_word_path();
        test_sized_stores();
        test_sized_loads();
        test_lui_link();
        test_no_write();
        $display("all tests passed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Simulation timed out after %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $fatal(1);
    end

endmodule
